/* Makefile */
# Verilator flow, run from the project root
TOP := tb_zx_mapper

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module zx_mapper_top
	verilator --lint-only --timing -f project.f --top-module $(TOP)

# the simulator exits non-zero on $fatal
sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* design/zx_bus_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module zx_bus_decode
	import zx_bus_pkg::*;
(
	input  wire             fclk,
	input  wire             rst_n,
	input  wire [15:0]      a,
	input  wire [7:0]       d,
	input  wire             iorq_n,
	input  wire             mreq_n,
	input  wire             rd_n,
	input  wire             wr_n,
	input  wire             m1_n,
	output bus_cycle_t      cycle,
	output logic [15:0]     cyc_addr,
	output logic [7:0]      cyc_data
);

	logic io_wr_cond;
	logic m1_cond;
	logic io_wr_prev;
	logic m1_prev;
	logic io_wr_start;
	logic m1_start;

	// m1_n high keeps the int ack cycle out
	assign io_wr_cond = !iorq_n && !wr_n && m1_n;
	assign m1_cond    = !mreq_n && !m1_n && !rd_n;

	assign io_wr_start = io_wr_cond && !io_wr_prev;
	assign m1_start    = m1_cond && !m1_prev;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_wr_prev <= 1'b0;
			m1_prev    <= 1'b0;
			cycle      <= cyc_none;
		end
		else
		begin
			io_wr_prev <= io_wr_cond;
			m1_prev    <= m1_cond;
			if (io_wr_start)
				cycle <= cyc_io_wr;
			else if (m1_start)
				cycle <= cyc_m1;
			else
				cycle <= cyc_none;
		end
	end

	// address and data frozen with the strobe
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cyc_addr <= '0;
			cyc_data <= '0;
		end
		else if (io_wr_start || m1_start)
		begin
			cyc_addr <= a;
			cyc_data <= d;
		end
	end

endmodule

`default_nettype wire

/* design/zx_bus_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// z80 bus activity
////////////////////////////////////////////////////////////////////////////

package zx_bus_pkg;

	// start of a bus cycle, valid for one fclk
	typedef enum logic [1:0]
	{
		cyc_none  = 2'd0,
		cyc_io_wr = 2'd1,
		cyc_m1    = 2'd2
	} bus_cycle_t;

endpackage

`default_nettype wire

/* design/zx_cfg.svh */
`ifndef ZX_CFG_SVH
`define ZX_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// i/o port decode
////////////////////////////////////////////////////////////////////////////

// ATM window page port, xxF7, window picked by A15:A14
`define ZX_PORT_F7_LOW      8'hF7
// ATM config port, bit 0 is pager enable
`define ZX_PORT_77_LOW      8'h77

////////////////////////////////////////////////////////////////////////////
// TR-DOS entry
////////////////////////////////////////////////////////////////////////////

// M1 in 3Dxx with BASIC48 in window 0
`define ZX_DOS_ENTRY_HIGH   8'h3D

////////////////////////////////////////////////////////////////////////////
// page numbers
////////////////////////////////////////////////////////////////////////////

`define ZX_ROM_EDITOR128    8'd0
`define ZX_ROM_BASIC48      8'd1
`define ZX_ROM_TRDOS        8'd2

// fixed pentagon ram in windows 1 and 2
`define ZX_RAM_WIN1         8'd5
`define ZX_RAM_WIN2         8'd2

`endif

/* design/zx_dos_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "zx_cfg.svh"

module zx_dos_ctrl
	import zx_bus_pkg::*;
(
	input  wire             fclk,
	input  wire             rst_n,
	input  wire bus_cycle_t cycle,
	input  wire [15:0]      cyc_addr,
	input  wire             basic48_mapped,
	output logic            dos
);

	logic m1_fetch;
	logic dos_on;
	logic dos_off;

	assign m1_fetch = (cycle == cyc_m1);

	// entry point in the 48k rom
	assign dos_on  = m1_fetch && basic48_mapped &&
	                 (cyc_addr[15:8] == `ZX_DOS_ENTRY_HIGH);
	// any fetch outside window 0 leaves dos
	assign dos_off = m1_fetch && (cyc_addr[15:14] != 2'd0);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			dos <= 1'b0;
		else if (dos_on)
			dos <= 1'b1;
		else if (dos_off)
			dos <= 1'b0;
	end

endmodule

`default_nettype wire

/* design/zx_mapper_top.sv */
`timescale 1ns/1ns
`default_nettype none

module zx_mapper_top
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
(
	input  wire             fclk,
	input  wire             rst_n,

	// z80 bus, already synchronous to fclk
	input  wire [15:0]      a,
	input  wire [7:0]       d,
	input  wire             iorq_n,
	input  wire             mreq_n,
	input  wire             rd_n,
	input  wire             wr_n,
	input  wire             m1_n,

	output page_t           mem_page,
	output logic            mem_rom,
	output logic            dos
);

	bus_cycle_t  cycle;
	logic [15:0] cyc_addr;
	logic [7:0]  cyc_data;
	logic        basic48_mapped;

	zx_page_if u_page_if ();

	zx_bus_decode u_bus_decode (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.a        (a),
		.d        (d),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.cycle    (cycle),
		.cyc_addr (cyc_addr),
		.cyc_data (cyc_data)
	);

	zx_port_regs u_port_regs (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.cycle    (cycle),
		.cyc_addr (cyc_addr),
		.cyc_data (cyc_data),
		.regs     (u_page_if.regs)
	);

	zx_dos_ctrl u_dos_ctrl (
		.fclk           (fclk),
		.rst_n          (rst_n),
		.cycle          (cycle),
		.cyc_addr       (cyc_addr),
		.basic48_mapped (basic48_mapped),
		.dos            (dos)
	);

	zx_window_map u_window_map (
		.a              (a),
		.dos            (dos),
		.map            (u_page_if.map),
		.mem_page       (mem_page),
		.mem_rom        (mem_rom),
		.basic48_mapped (basic48_mapped)
	);

endmodule

`default_nettype wire

/* design/zx_mem_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// memory mapping types
////////////////////////////////////////////////////////////////////////////

package zx_mem_pkg;

	typedef logic [7:0] page_t;

	// A15:A14
	typedef logic [1:0] win_idx_t;

	// same bit layout as the byte written to xxF7
	typedef struct packed
	{
		logic       rom;
		logic [6:0] page;
	} atm_page_t;

	// 7FFD bits 2:0
	typedef logic [2:0] ram_bank_t;

endpackage

`default_nettype wire

/* design/zx_page_if.sv */
`timescale 1ns/1ns
`default_nettype none

// paging register state, register block to mapper
interface zx_page_if
	import zx_mem_pkg::*;
();

	ram_bank_t          ram_bank;
	logic               rom_sel;
	logic               pager_en;
	atm_page_t [3:0]    win_regs;

	modport regs
	(
		output ram_bank,
		output rom_sel,
		output pager_en,
		output win_regs
	);

	modport map
	(
		input ram_bank,
		input rom_sel,
		input pager_en,
		input win_regs
	);

endinterface

`default_nettype wire

/* design/zx_port_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "zx_cfg.svh"

module zx_port_regs
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
(
	input  wire             fclk,
	input  wire             rst_n,
	input  wire bus_cycle_t cycle,
	input  wire [15:0]      cyc_addr,
	input  wire [7:0]       cyc_data,
	zx_page_if.regs         regs
);

	logic     io_wr;
	logic     hit_7ffd;
	logic     hit_77;
	logic     hit_f7;
	logic     lock_7ffd;
	win_idx_t win_sel;

	////////////////////////////////////////////////////////////////////////////
	// port decode
	////////////////////////////////////////////////////////////////////////////

	assign io_wr = (cycle == cyc_io_wr);

	// 7FFD is partially decoded, A15=0 and A1=0
	assign hit_7ffd = io_wr && !cyc_addr[15] && !cyc_addr[1];
	assign hit_77   = io_wr && (cyc_addr[7:0] == `ZX_PORT_77_LOW);
	assign hit_f7   = io_wr && (cyc_addr[7:0] == `ZX_PORT_F7_LOW);

	assign win_sel = cyc_addr[15:14];

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			regs.ram_bank <= '0;
			regs.rom_sel  <= 1'b0;
			lock_7ffd     <= 1'b0;
		end
		else if (hit_7ffd && !lock_7ffd)
		begin
			regs.ram_bank <= ram_bank_t'(cyc_data[2:0]);
			regs.rom_sel  <= cyc_data[4];
			// 48k lock, held until reset
			lock_7ffd     <= cyc_data[5];
		end
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			regs.pager_en <= 1'b0;
		else if (hit_77)
			regs.pager_en <= cyc_data[0];
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			regs.win_regs <= '0;
		else if (hit_f7)
			regs.win_regs[win_sel] <= atm_page_t'(cyc_data);
	end

endmodule

`default_nettype wire

/* design/zx_window_map.sv */
`timescale 1ns/1ns
`default_nettype none

`include "zx_cfg.svh"

module zx_window_map
	import zx_mem_pkg::*;
(
	input  wire [15:0]      a,
	input  wire             dos,
	zx_page_if.map          map,
	output page_t           mem_page,
	output logic            mem_rom,
	output logic            basic48_mapped
);

	logic  win0_rom;
	page_t win0_page;

	// pentagon map with the pager off, ATM window registers with it on
	function automatic void resolve_win(
		input  win_idx_t w,
		output logic     rom,
		output page_t    page
	);
		rom  = 1'b0;
		page = '0;
		if (map.pager_en)
		begin
			rom  = map.win_regs[w].rom;
			page = {1'b0, map.win_regs[w].page};
			// dos overrides a rom entry in window 0
			if ((w == 2'd0) && rom && dos)
				page = `ZX_ROM_TRDOS;
		end
		else
		begin
			case (w)
				2'd0:
				begin
					rom = 1'b1;
					if (dos)
						page = `ZX_ROM_TRDOS;
					else if (map.rom_sel)
						page = `ZX_ROM_BASIC48;
					else
						page = `ZX_ROM_EDITOR128;
				end
				2'd1:    page = `ZX_RAM_WIN1;
				2'd2:    page = `ZX_RAM_WIN2;
				default: page = {5'b0, map.ram_bank};
			endcase
		end
	endfunction

	always_comb
	begin
		resolve_win(a[15:14], mem_rom, mem_page);
	end

	// window 0 on its own, for the dos entry check
	always_comb
	begin
		resolve_win(2'd0, win0_rom, win0_page);
	end

	assign basic48_mapped = win0_rom && (win0_page == `ZX_ROM_BASIC48);

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/zx_bus_pkg.sv
design/zx_mem_pkg.sv
design/zx_page_if.sv
design/zx_bus_decode.sv
design/zx_port_regs.sv
design/zx_window_map.sv
design/zx_dos_ctrl.sv
design/zx_mapper_top.sv
verif/tb_zx_mapper.sv

/* verif/tb_zx_mapper.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_zx_mapper
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
();

	localparam string DATA_FILE      = "verif/zx_mapper_testdata.txt";
	localparam int    HOLD_CYCLES    = 3;
	localparam int    STROBE_TIMEOUT = 4;

	logic        fclk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  d;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	page_t       mem_page;
	logic        mem_rom;
	logic        dos;
	int          seed;

	zx_mapper_top u_zx_mapper_top (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.a        (a),
		.d        (d),
		.iorq_n   (iorq_n),
		.mreq_n   (mreq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.mem_page (mem_page),
		.mem_rom  (mem_rom),
		.dos      (dos)
	);

	initial
	begin
		fclk = 1'b0;
		forever #4 fclk = ~fclk;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic skip_comment(input int fd);
		int c;
		c = $fgetc(fd);
		while ((c != 10) && (c != -1))
			c = $fgetc(fd);
	endtask

	// one bus cycle held for HOLD_CYCLES then released
	task automatic drive_bus_op(
		input logic [7:0]  op,
		input logic [15:0] addr,
		input logic [7:0]  data
	);
		bus_cycle_t expected;
		bus_cycle_t seen;
		int         waited;
		expected = (op == "W") ? cyc_io_wr : cyc_m1;
		seen     = cyc_none;
		waited   = 0;
		a        = addr;
		d        = data;
		if (op == "W")
		begin
			iorq_n = 1'b0;
			wr_n   = 1'b0;
		end
		else
		begin
			mreq_n = 1'b0;
			m1_n   = 1'b0;
			rd_n   = 1'b0;
		end
		while ((seen == cyc_none) && (waited < STROBE_TIMEOUT))
		begin
			@(negedge fclk);
			waited++;
			seen = u_zx_mapper_top.cycle;
		end
		assert (seen != cyc_none)
		else
			stop_with_error("timeout: the bus decoder never flagged the driven cycle");
		assert (seen == expected)
		else
			stop_with_error($sformatf("Fail at %0t: cycle kind %0d, expected %0d",
				$time, seen, expected));
		// strobe stays quiet while the bus is still held
		while (waited < HOLD_CYCLES)
		begin
			@(negedge fclk);
			waited++;
			assert (u_zx_mapper_top.cycle == cyc_none)
			else
				stop_with_error($sformatf("Fail at %0t: cycle strobe longer than one fclk",
					$time));
		end
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		// decoder has to see the bus idle once
		@(negedge fclk);
	endtask

	task automatic check_mapping(
		input int          rec,
		input logic [15:0] addr,
		input page_t       exp_page,
		input logic        exp_rom,
		input logic        exp_dos
	);
		a = addr;
		@(negedge fclk);
		assert (mem_page === exp_page)
		else
			stop_with_error($sformatf("Fail at %0t: record %0d a=%h mem_page %h, expected %h",
				$time, rec, addr, mem_page, exp_page));
		assert (mem_rom === exp_rom)
		else
			stop_with_error($sformatf("Fail at %0t: record %0d a=%h mem_rom %b, expected %b",
				$time, rec, addr, mem_rom, exp_rom));
		assert (dos === exp_dos)
		else
			stop_with_error($sformatf("Fail at %0t: record %0d dos %b, expected %b",
				$time, rec, dos, exp_dos));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus from the data file
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int          fd;
		int          n;
		int          rec_no;
		int          idle;
		bit          done;
		logic [7:0]  op;
		logic [15:0] f_addr;
		logic [7:0]  f_data;
		page_t       f_page;
		logic        f_rom;
		logic        f_dos;
		seed   = 32'h397921a8;
		rst_n  = 1'b0;
		a      = '0;
		d      = '0;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		rec_no = 0;
		done   = 1'b0;
		repeat (8) @(negedge fclk);
		rst_n = 1'b1;
		@(negedge fclk);
		fd = $fopen(DATA_FILE, "r");
		assert (fd != 0)
		else
			stop_with_error("cannot open the data file verif/zx_mapper_testdata.txt");
		while (!done)
		begin
			n = $fscanf(fd, " %c", op);
			if (n != 1)
				done = 1'b1;
			else if (op == "#")
				skip_comment(fd);
			else
			begin
				n = $fscanf(fd, "%h %h %h %h %h", f_addr, f_data, f_page, f_rom, f_dos);
				assert (n == 5)
				else
					stop_with_error("a record in the data file has missing fields");
				rec_no++;
				case (op)
					"W", "M":
					begin
						drive_bus_op(op, f_addr, f_data);
						idle = $unsigned($random(seed)) % 4;
						repeat (idle) @(negedge fclk);
					end
					"C":     check_mapping(rec_no, f_addr, f_page, f_rom, f_dos);
					default: stop_with_error("unknown operation letter in the data file");
				endcase
			end
		end
		$fclose(fd);
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/zx_mapper_testdata.txt */
# columns: op addr data page rom dos, values in hex
# op W = i/o write, M = m1 fetch, C = check; page rom dos only matter for C
# after reset, pentagon map
C 0000 00 00 1 0
C 4000 00 05 0 0
C 8000 00 02 0 0
C c000 00 00 0 0
# 7ffd bank and rom select
W 7ffd 03 00 0 0
C c000 00 03 0 0
C 0000 00 00 1 0
W 7ffd 16 00 0 0
C c000 00 06 0 0
C 0000 00 01 1 0
C 4000 00 05 0 0
# dos entry from basic48
M 3d2f 00 00 0 0
C 0000 00 02 1 1
C c000 00 06 0 1
# fetch in window 0 keeps dos
M 0100 00 00 0 0
C 0000 00 02 1 1
# fetches in windows 1, 2, 3 leave dos
M 8000 00 00 0 0
C 0000 00 01 1 0
M 3d00 00 00 0 0
C 0000 00 02 1 1
M 4123 00 00 0 0
C 0000 00 01 1 0
M 3d00 00 00 0 0
M fffe 00 00 0 0
C 0000 00 01 1 0
# no dos entry from editor128
W 7ffd 07 00 0 0
M 3d13 00 00 0 0
C 0000 00 00 1 0
C c000 00 07 0 0
# atm window registers, pager still off
W 00f7 83 00 0 0
W 40f7 11 00 0 0
W 80f7 2a 00 0 0
W c0f7 c5 00 0 0
C 4000 00 05 0 0
W 0077 01 00 0 0
C 0000 00 03 1 0
C 4000 00 11 0 0
C 8000 00 2a 0 0
C c000 00 45 1 0
# pager on, dos override of a rom entry
W 00f7 81 00 0 0
C 0000 00 01 1 0
M 3d00 00 00 0 0
C 0000 00 02 1 1
C 4000 00 11 0 1
W 00f7 09 00 0 0
C 0000 00 09 0 1
M 4000 00 00 0 0
C 0000 00 09 0 0
W 0077 00 00 0 0
C 0000 00 00 1 0
C c000 00 07 0 0
# 7ffd lock
W 7ffd 31 00 0 0
C c000 00 01 0 0
C 0000 00 01 1 0
W 7ffd 04 00 0 0
C c000 00 01 0 0
C 0000 00 01 1 0
